// File: tb.f
+incdir+rtl
rtl/pcie_axil_pkg.sv
rtl/cq_req_decode.sv
rtl/cq_completer_fsm.sv
rtl/cc_tlp_build.sv
rtl/cc_skid_buffer.sv
rtl/pcie_axil_master.sv
verification/tb_pcie_axil_master.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_pcie_axil_master
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing
PASS_TEXT ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: verification/tb_pcie_axil_master.sv
// testbench with AXI-Lite slave model, CC monitor, directed tests and watchdog
module tb_pcie_axil_master
    import pcie_axil_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam req_id_t cpl_id = 16'h01a0;
    localparam int max_requests = 40;       // the tests issue 36 request beats
    localparam int request_bound_ns = 500;  // slow request under random readies

    logic clk;
    logic rst;
    pcie_data_t cq_tdata;
    axil_strb_t cq_tuser;
    logic cq_tlast;
    logic cq_tvalid;
    logic cq_tready;
    pcie_data_t cc_tdata;
    pcie_keep_t cc_tkeep;
    logic cc_tlast;
    logic cc_tvalid;
    logic cc_tready = 1'b1;
    axil_addr_t awaddr;
    logic awvalid;
    logic awready = 1'b0;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic wvalid;
    logic wready = 1'b0;
    logic bvalid = 1'b0;
    logic bready;
    axil_addr_t araddr;
    logic arvalid;
    logic arready = 1'b0;
    axil_data_t rdata = '0;
    logic rvalid = 1'b0;
    logic rready;
    req_id_t completer_id;
    logic completer_id_en;
    logic stat_err_cor;
    logic stat_err_uncor;

    // slave model state
    axil_data_t mem [0:255];
    axil_addr_t aw_addr_q;
    axil_addr_t ar_addr_q;
    axil_data_t w_data_q;
    axil_strb_t w_strb_q;
    logic aw_got = 1'b0;
    logic w_got = 1'b0;
    logic cc_random = 1'b0;  // random cc_tready when set
    logic [31:0] lfsr = 32'h772a;
    int aw_count = 0;
    int b_count = 0;
    int cor_count = 0;
    int uncor_count = 0;
    int errors = 0;

    pcie_data_t cc_data_q[$];
    pcie_keep_t cc_keep_q[$];
    logic cc_last_q[$];

    pcie_axil_master dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic next_rand_bit();
        lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
        return lfsr[0];
    endfunction

    function automatic axil_data_t fill_word(input logic [7:0] idx);
        return {idx, ~idx, idx ^ 8'h5a, idx + 8'h3c};
    endfunction

    function automatic axil_data_t merge_bytes(input axil_data_t old, input axil_data_t data,
                                               input axil_strb_t be);
        axil_data_t word;
        word = old;
        for (int i = 0; i < 4; i++) begin
            if (be[i])
                word[8*i +: 8] = data[8*i +: 8];
        end
        return word;
    endfunction

    // AXI-Lite slave with handshakes sampled at the edge and outputs driven 1 ns later
    always @(posedge clk) begin
        logic aw_hs;
        logic w_hs;
        logic b_hs;
        logic ar_hs;
        logic r_hs;
        logic fill_mem;
        logic cc_rand_mode;
        aw_hs = awvalid && awready;
        w_hs = wvalid && wready;
        b_hs = bvalid && bready;
        ar_hs = arvalid && arready;
        r_hs = rvalid && rready;
        fill_mem = rst;
        cc_rand_mode = cc_random;
        if (aw_hs) begin
            aw_addr_q = awaddr;
            aw_got = 1'b1;
            aw_count++;
        end
        if (w_hs) begin
            w_data_q = wdata;
            w_strb_q = wstrb;
            w_got = 1'b1;
        end
        if (ar_hs)
            ar_addr_q = araddr;
        if (b_hs)
            b_count++;
        #1;
        if (fill_mem) begin
            for (int i = 0; i < 256; i++)
                mem[i] = fill_word(8'(i));
        end
        if (b_hs)
            bvalid = 1'b0;
        if (aw_got && w_got) begin
            mem[aw_addr_q[9:2]] = merge_bytes(mem[aw_addr_q[9:2]], w_data_q, w_strb_q);
            aw_got = 1'b0;
            w_got = 1'b0;
            bvalid = 1'b1;
        end
        if (r_hs)
            rvalid = 1'b0;
        if (ar_hs) begin
            rvalid = 1'b1;
            rdata = mem[ar_addr_q[9:2]];
        end
        awready = next_rand_bit();
        wready = next_rand_bit();
        arready = next_rand_bit();
        cc_tready = cc_rand_mode ? next_rand_bit() : 1'b1;
    end

    // CC beats and status pulses
    always @(posedge clk) begin
        if (cc_tvalid && cc_tready) begin
            cc_data_q.push_back(cc_tdata);
            cc_keep_q.push_back(cc_tkeep);
            cc_last_q.push_back(cc_tlast);
        end
        if (stat_err_cor)
            cor_count++;
        if (stat_err_uncor)
            uncor_count++;
    end

    function automatic logic [1:0] first_lane(input axil_strb_t be);
        logic [1:0] lane;
        lane = 2'd0;
        for (int i = 3; i >= 0; i--) begin
            if (be[i])
                lane = 2'(i);
        end
        return lane;
    endfunction

    // span from first to last enabled byte or 1 when at most one is set
    function automatic logic [12:0] span_bytes(input axil_strb_t be);
        int lo;
        int hi;
        lo = -1;
        hi = -1;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                if (lo < 0)
                    lo = i;
                hi = i;
            end
        end
        return (lo < 0) ? 13'd1 : 13'(hi - lo + 1);
    endfunction

    // requester id, tc and attr follow the tag
    function automatic pcie_data_t make_req(input req_type_e kind, input axil_addr_t addr,
                                            input dw_count_t len, input tlp_tag_t tag,
                                            input axil_data_t data);
        pcie_data_t beat;
        beat = '0;
        beat[63:2] = 62'(addr[31:2]);
        beat[74:64] = len;
        beat[78:75] = kind;
        beat[95:80] = {8'hc3, tag};
        beat[103:96] = tag;
        beat[123:121] = tag[2:0];
        beat[126:124] = tag[5:3];
        beat[159:128] = data;
        return beat;
    endfunction

    function automatic pcie_data_t expected_cpl(input cpl_status_e st, input axil_addr_t addr,
                                                input axil_strb_t be, input tlp_tag_t tag,
                                                input logic has_data, input axil_data_t data);
        pcie_data_t beat;
        beat = '0;
        beat[6:0] = {addr[6:2], first_lane(be)};
        beat[28:16] = span_bytes(be);
        beat[42:32] = has_data ? 11'd1 : 11'd0;
        beat[45:43] = st;
        beat[63:48] = {8'hc3, tag};
        beat[71:64] = tag;
        beat[87:72] = cpl_id;
        beat[88] = 1'b1;
        beat[91:89] = tag[2:0];
        beat[94:92] = tag[5:3];
        beat[127:96] = has_data ? data : 32'h0;
        return beat;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %0h, got %0h", name, exp, act);
        end
    endtask

    // starts 1 ns after an edge and returns 1 ns after the accepting edge
    task automatic send_beat(input pcie_data_t data, input axil_strb_t be, input logic last);
        cq_tdata = data;
        cq_tuser = be;
        cq_tlast = last;
        cq_tvalid = 1'b1;
        do @(posedge clk); while (!cq_tready);
        #1;
        cq_tvalid = 1'b0;
    endtask

    task automatic take_cpl(input string name, input pcie_data_t exp_beat,
                            input pcie_keep_t exp_keep);
        pcie_data_t beat;
        pcie_keep_t keep;
        logic last;
        while (cc_data_q.size() == 0) begin
            @(posedge clk);
            #1;
        end
        beat = cc_data_q.pop_front();
        keep = cc_keep_q.pop_front();
        last = cc_last_q.pop_front();
        if (beat !== exp_beat) begin
            errors++;
            $display("FAILED %s: expected beat %h, got %h", name, exp_beat, beat);
        end
        check_value({name, " keep"}, 32'(exp_keep), 32'(keep));
        if (last !== 1'b1) begin
            errors++;
            $display("%s: completion came without tlast", name);
        end
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
        if (cc_data_q.size() != 0) begin
            errors++;
            $display("%s: unexpected completion on the CC stream", name);
        end
    endtask

    task automatic reset_checks();
        check_value("reset cq_tready", 32'd0, 32'(cq_tready));
        check_value("reset cc_tvalid", 32'd0, 32'(cc_tvalid));
        check_value("reset axi", 32'd0, 32'({awvalid, wvalid, arvalid, bready, rready}));
        check_value("reset status", 32'd0, 32'({stat_err_cor, stat_err_uncor}));
        @(posedge clk);
        #1;
        check_value("cq_tready after reset", 32'd1, 32'(cq_tready));
    endtask

    task automatic mem_write_then_read();
        int b_start;
        b_start = b_count;
        send_beat(make_req(REQ_MEM_WRITE, 32'h0000_0140, 11'd1, 8'h01, 32'h1234_5678),
                  4'hf, 1'b1);
        while (b_count == b_start) begin
            @(posedge clk);
            #1;
        end
        expect_quiet("mem_write_then_read", 3);
        check_value("mem_write_then_read memory", 32'h1234_5678, mem[8'h50]);
        send_beat(make_req(REQ_MEM_READ, 32'h0000_0140, 11'd1, 8'h2b, 32'h0), 4'hf, 1'b1);
        take_cpl("mem_write_then_read",
                 expected_cpl(CPL_SC, 32'h0000_0140, 4'hf, 8'h2b, 1'b1, 32'h1234_5678), 8'h0f);
    endtask

    task automatic io_write();
        axil_data_t exp_word;
        exp_word = merge_bytes(fill_word(8'h21), 32'haabb_ccdd, 4'b0110);
        send_beat(make_req(REQ_IO_WRITE, 32'h2000_0084, 11'd1, 8'h35, 32'haabb_ccdd),
                  4'b0110, 1'b1);
        take_cpl("io_write", expected_cpl(CPL_SC, 32'h2000_0084, 4'b0110, 8'h35, 1'b0, 32'h0),
                 8'h07);
        check_value("io_write memory", exp_word, mem[8'h21]);
        check_value("io_write awaddr", 32'h2000_0084, aw_addr_q);
    endtask

    task automatic byte_enable_offsets();
        axil_strb_t patterns [0:11];
        axil_addr_t addr;
        tlp_tag_t tag;
        patterns = '{4'b0001, 4'b0010, 4'b0100, 4'b1000, 4'b0011, 4'b0110,
                     4'b1100, 4'b0111, 4'b1110, 4'b1001, 4'b1111, 4'b0000};
        for (int i = 0; i < 12; i++) begin
            addr = 32'h1000_0180 + 32'(i * 4);  // upper bits pass through to araddr
            tag = 8'h40 + 8'(i);
            send_beat(make_req(REQ_MEM_READ, addr, 11'd1, tag, 32'h0), patterns[i], 1'b1);
            take_cpl("byte_enable_offsets",
                     expected_cpl(CPL_SC, addr, patterns[i], tag, 1'b1, fill_word(addr[9:2])),
                     8'h0f);
            check_value("byte_enable_offsets araddr", addr, ar_addr_q);
        end
    endtask

    task automatic bad_length();
        int cor_start;
        int uncor_start;
        int aw_start;
        cor_start = cor_count;
        send_beat(make_req(REQ_MEM_READ, 32'h0000_01c8, 11'd2, 8'h52, 32'h0), 4'b1100, 1'b0);
        check_value("bad_length read stat_err_cor", 32'd1, 32'(stat_err_cor));
        send_beat('0, 4'h0, 1'b1);  // second dword of the long read
        take_cpl("bad_length read",
                 expected_cpl(CPL_CA, 32'h0000_01c8, 4'b1100, 8'h52, 1'b0, 32'h0), 8'h07);
        check_value("bad_length read cor pulses", 32'(cor_start + 1), 32'(cor_count));

        uncor_start = uncor_count;
        aw_start = aw_count;
        send_beat(make_req(REQ_MEM_WRITE, 32'h0000_01cc, 11'd2, 8'h53, 32'h5555_aaaa),
                  4'hf, 1'b1);
        check_value("bad_length write stat_err_uncor", 32'd1, 32'(stat_err_uncor));
        expect_quiet("bad_length write", 4);
        check_value("bad_length write memory", fill_word(8'h73), mem[8'h73]);
        check_value("bad_length write aw count", 32'(aw_start), 32'(aw_count));
        check_value("bad_length write uncor pulses", 32'(uncor_start + 1), 32'(uncor_count));
    endtask

    task automatic unsupported_requests();
        int cor_start;
        int uncor_start;
        cor_start = cor_count;
        send_beat(make_req(REQ_CFG_READ_0, 32'h0000_0010, 11'd1, 8'h61, 32'h0), 4'hf, 1'b1);
        check_value("unsupported cfg stat_err_cor", 32'd1, 32'(stat_err_cor));
        take_cpl("unsupported cfg",
                 expected_cpl(CPL_UR, 32'h0000_0010, 4'hf, 8'h61, 1'b0, 32'h0), 8'h07);
        check_value("unsupported cfg cor pulses", 32'(cor_start + 1), 32'(cor_count));

        uncor_start = uncor_count;
        send_beat(make_req(REQ_MSG, 32'h0000_0020, 11'd1, 8'h62, 32'h0), 4'hf, 1'b1);
        check_value("unsupported msg stat_err_uncor", 32'd1, 32'(stat_err_uncor));
        expect_quiet("unsupported msg", 4);
        check_value("unsupported msg uncor pulses", 32'(uncor_start + 1), 32'(uncor_count));
    endtask

    task automatic back_pressure_burst();
        axil_addr_t addr;
        tlp_tag_t tag;
        cc_random = 1'b1;
        for (int i = 0; i < 16; i++) begin
            addr = 32'h0000_0240 + 32'(i * 4);
            tag = 8'h80 + 8'(i);
            send_beat(make_req(REQ_MEM_READ, addr, 11'd1, tag, 32'h0), 4'hf, 1'b1);
        end
        // completions come back in request order with their own tags
        for (int i = 0; i < 16; i++) begin
            addr = 32'h0000_0240 + 32'(i * 4);
            tag = 8'h80 + 8'(i);
            take_cpl("back_pressure_burst",
                     expected_cpl(CPL_SC, addr, 4'hf, tag, 1'b1, fill_word(addr[9:2])), 8'h0f);
        end
        cc_random = 1'b0;
        expect_quiet("back_pressure_burst", 4);
    endtask

    initial begin
        rst = 1'b1;
        cq_tdata = '0;
        cq_tuser = '0;
        cq_tlast = 1'b0;
        cq_tvalid = 1'b0;
        completer_id = cpl_id;
        completer_id_en = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_checks();
        mem_write_then_read();
        io_write();
        byte_enable_offsets();
        bad_length();
        unsupported_requests();
        back_pressure_burst();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(max_requests * request_bound_ns);
        $display("watchdog expired with %0d errors before the tests finished", errors);
        $display("tests failed");
        $finish;
    end

endmodule

// File: rtl/pcie_axil_master.sv
// PCIe CQ/CC to AXI-Lite master top level
module pcie_axil_master
    import pcie_axil_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pcie_data_t cq_tdata,
    input  axil_strb_t cq_tuser,  // first byte enable
    input  logic       cq_tlast,
    input  logic       cq_tvalid,
    output logic       cq_tready,
    output pcie_data_t cc_tdata,
    output pcie_keep_t cc_tkeep,
    output logic       cc_tlast,
    output logic       cc_tvalid,
    input  logic       cc_tready,
    output axil_addr_t awaddr,
    output logic       awvalid,
    input  logic       awready,
    output axil_data_t wdata,
    output axil_strb_t wstrb,
    output logic       wvalid,
    input  logic       wready,
    input  logic       bvalid,
    output logic       bready,
    output axil_addr_t araddr,
    output logic       arvalid,
    input  logic       arready,
    input  axil_data_t rdata,
    input  logic       rvalid,
    output logic       rready,
    input  req_id_t    completer_id,
    input  logic       completer_id_en,
    output logic       stat_err_cor,
    output logic       stat_err_uncor
);
    axil_addr_t hdr_addr;
    req_id_t hdr_requester_id;
    tlp_tag_t hdr_tag;
    tlp_tc_t hdr_tc;
    tlp_attr_t hdr_attr;
    axil_strb_t hdr_first_be;
    axil_data_t req_data;
    logic req_is_read;
    logic req_is_write;
    logic req_posted;
    logic req_len_ok;

    axil_addr_t axil_addr;
    logic cpl_valid;
    req_id_t requester_id;
    tlp_tag_t tag;
    tlp_tc_t tc;
    tlp_attr_t attr;
    axil_strb_t first_be;
    cpl_status_e status;
    logic cpl_data;
    pcie_data_t cpl_tdata;
    pcie_keep_t cpl_tkeep;
    logic cc_ready_early;

    assign awaddr = axil_addr;  // one request in flight, shared address
    assign araddr = axil_addr;

    cq_req_decode u_decode (
        .cq_tdata, .cq_tuser, .cq_tlast,
        .hdr_addr, .hdr_type (), .hdr_requester_id, .hdr_tag, .hdr_tc, .hdr_attr,
        .hdr_first_be, .req_data, .req_is_read, .req_is_write, .req_posted, .req_len_ok
    );

    cq_completer_fsm u_fsm (
        .clk, .rst, .cq_tvalid, .cq_tlast,
        .hdr_addr, .hdr_requester_id, .hdr_tag, .hdr_tc, .hdr_attr, .hdr_first_be,
        .req_data, .req_is_read, .req_is_write, .req_posted, .req_len_ok,
        .awready, .wready, .bvalid, .arready, .rvalid, .cc_ready_early,
        .cq_tready, .axil_addr, .awvalid, .wdata, .wstrb, .wvalid, .bready,
        .arvalid, .rready, .cpl_valid,
        .requester_id, .tag, .tc, .attr, .first_be, .status, .cpl_data,
        .stat_err_cor, .stat_err_uncor
    );

    cc_tlp_build u_build (
        .axil_addr, .first_be, .status, .cpl_data, .requester_id, .tag, .tc, .attr,
        .completer_id, .completer_id_en, .rdata, .cpl_tdata, .cpl_tkeep
    );

    cc_skid_buffer u_skid (
        .clk, .rst,
        .in_tdata (cpl_tdata),
        .in_tkeep (cpl_tkeep),
        .in_tvalid (cpl_valid),
        .cc_tready,
        .ready_early (cc_ready_early),
        .cc_tdata, .cc_tkeep, .cc_tvalid, .cc_tlast
    );

endmodule

// File: rtl/cc_skid_buffer.sv
// CC output register with temporary skid stage and early ready
module cc_skid_buffer
    import pcie_axil_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  pcie_data_t in_tdata,
    input  pcie_keep_t in_tkeep,
    input  logic       in_tvalid,
    input  logic       cc_tready,
    output logic       ready_early,
    output pcie_data_t cc_tdata,
    output pcie_keep_t cc_tkeep,
    output logic       cc_tvalid,
    output logic       cc_tlast
);
    pcie_data_t temp_tdata;
    pcie_keep_t temp_tkeep;
    logic temp_tvalid;
    logic ready_reg;
    logic out_valid_next;
    logic temp_valid_next;
    logic in_to_out;
    logic in_to_temp;
    logic temp_to_out;

    // ready next cycle if the output drains or both stages are empty
    assign ready_early = cc_tready || (!temp_tvalid && !cc_tvalid);
    assign cc_tlast = cc_tvalid;  // completions are single beat

    always_comb begin
        out_valid_next = cc_tvalid;
        temp_valid_next = temp_tvalid;
        in_to_out = 1'b0;
        in_to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (ready_reg) begin
            if (cc_tready || !cc_tvalid) begin
                out_valid_next = in_tvalid;
                in_to_out = 1'b1;
            end else begin
                temp_valid_next = in_tvalid;  // output stalled
                in_to_temp = 1'b1;
            end
        end else if (cc_tready) begin
            out_valid_next = temp_tvalid;
            temp_valid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cc_tvalid <= 1'b0;
            temp_tvalid <= 1'b0;
            ready_reg <= 1'b0;
        end else begin
            cc_tvalid <= out_valid_next;
            temp_tvalid <= temp_valid_next;
            ready_reg <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            cc_tdata <= in_tdata;
            cc_tkeep <= in_tkeep;
        end else if (temp_to_out) begin
            cc_tdata <= temp_tdata;
            cc_tkeep <= temp_tkeep;
        end
        if (in_to_temp) begin
            temp_tdata <= in_tdata;
            temp_tkeep <= in_tkeep;
        end
    end

endmodule

// File: rtl/cc_tlp_build.sv
// completion descriptor, keep and payload assembly
module cc_tlp_build
    import pcie_axil_pkg::*;
(
    input  axil_addr_t  axil_addr,
    input  axil_strb_t  first_be,
    input  cpl_status_e status,
    input  logic        cpl_data,
    input  req_id_t     requester_id,
    input  tlp_tag_t    tag,
    input  tlp_tc_t     tc,
    input  tlp_attr_t   attr,
    input  req_id_t     completer_id,
    input  logic        completer_id_en,
    input  axil_data_t  rdata,
    output pcie_data_t  cpl_tdata,
    output pcie_keep_t  cpl_tkeep
);
    logic [1:0] lower_byte;
    logic [12:0] byte_count;
    axil_data_t payload;
    cpl_hdr_t hdr;

    // offset of the first enabled byte
    always_comb begin
        casez (first_be)
            4'bzzz1: lower_byte = 2'd0;
            4'bzz10: lower_byte = 2'd1;
            4'bz100: lower_byte = 2'd2;
            4'b1000: lower_byte = 2'd3;
            default: lower_byte = 2'd0;
        endcase
    end

    // span from first to last enabled byte
    always_comb begin
        casez (first_be)
            4'b0011, 4'b0110, 4'b1100: byte_count = 13'd2;
            4'b01z1, 4'b1z10: byte_count = 13'd3;
            4'b1zz1: byte_count = 13'd4;
            default: byte_count = 13'd1;  // one byte or none
        endcase
    end

    always_comb begin
        hdr = '0;
        hdr[6:0] = {axil_addr[6:2], lower_byte};
        hdr[28:16] = byte_count;
        hdr[42:32] = cpl_data ? 11'd1 : 11'd0;  // dword count
        hdr[45:43] = status;
        hdr[63:48] = requester_id;
        hdr[71:64] = tag;
        hdr[87:72] = completer_id;
        hdr[88] = completer_id_en;
        hdr[91:89] = tc;
        hdr[94:92] = attr;
    end

    assign payload = cpl_data ? rdata : '0;
    assign cpl_tdata = pcie_data_t'({payload, hdr});
    assign cpl_tkeep = pcie_keep_t'({cpl_data, 3'b111});

endmodule

// File: rtl/cq_completer_fsm.sv
// request/response FSM: CQ intake, AXI-Lite issue and completion handoff
module cq_completer_fsm
    import pcie_axil_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cq_tvalid,
    input  logic        cq_tlast,
    input  axil_addr_t  hdr_addr,
    input  req_id_t     hdr_requester_id,
    input  tlp_tag_t    hdr_tag,
    input  tlp_tc_t     hdr_tc,
    input  tlp_attr_t   hdr_attr,
    input  axil_strb_t  hdr_first_be,
    input  axil_data_t  req_data,
    input  logic        req_is_read,
    input  logic        req_is_write,
    input  logic        req_posted,
    input  logic        req_len_ok,
    input  logic        awready,
    input  logic        wready,
    input  logic        bvalid,
    input  logic        arready,
    input  logic        rvalid,
    input  logic        cc_ready_early,
    output logic        cq_tready,
    output axil_addr_t  axil_addr,
    output logic        awvalid,
    output axil_data_t  wdata,
    output axil_strb_t  wstrb,
    output logic        wvalid,
    output logic        bready,
    output logic        arvalid,
    output logic        rready,
    output logic        cpl_valid,
    output req_id_t     requester_id,
    output tlp_tag_t    tag,
    output tlp_tc_t     tc,
    output tlp_attr_t   attr,
    output axil_strb_t  first_be,
    output cpl_status_e status,
    output logic        cpl_data,
    output logic        stat_err_cor,
    output logic        stat_err_uncor
);
    fsm_state_e state;
    fsm_state_e state_next;
    logic cq_tready_next;
    logic awvalid_next;
    logic wvalid_next;
    logic bready_next;
    logic arvalid_next;
    logic rready_next;
    logic cor_next;
    logic uncor_next;
    logic posted;        // request needs no completion
    logic cc_ready_reg;  // skid buffer takes input while this is high
    logic cq_accept;

    assign cq_accept = cq_tready && cq_tvalid;
    assign wstrb = first_be;

    always_comb begin
        state_next = state;
        cq_tready_next = 1'b0;
        awvalid_next = awvalid && !awready;  // drop after handshake
        wvalid_next = wvalid && !wready;
        arvalid_next = arvalid && !arready;
        bready_next = 1'b0;
        rready_next = 1'b0;
        cor_next = 1'b0;
        uncor_next = 1'b0;
        cpl_valid = 1'b0;

        case (state)
            ST_IDLE: begin
                cq_tready_next = cc_ready_early;
                if (cq_accept) begin
                    if (req_is_read && req_len_ok) begin
                        arvalid_next = 1'b1;
                        rready_next = cc_ready_early;
                        cq_tready_next = 1'b0;
                        state_next = ST_READ;
                    end else if (req_is_write && req_len_ok) begin
                        awvalid_next = 1'b1;
                        wvalid_next = 1'b1;
                        bready_next = cc_ready_early;
                        cq_tready_next = 1'b0;
                        state_next = ST_WRITE;
                    end else begin
                        // CA or UR, error class follows posting
                        cor_next = !req_posted;
                        uncor_next = req_posted;
                        if (!cq_tlast) begin
                            cq_tready_next = 1'b1;
                            state_next = ST_WAIT_END;
                        end else if (!req_posted) begin
                            cq_tready_next = 1'b0;
                            state_next = ST_CPL;
                        end
                    end
                end
            end
            ST_READ: begin
                rready_next = cc_ready_early;
                if (rready && rvalid) begin
                    cpl_valid = 1'b1;  // rdata goes out this cycle
                    rready_next = 1'b0;
                    cq_tready_next = cc_ready_early;
                    state_next = ST_IDLE;
                end
            end
            ST_WRITE: begin
                bready_next = cc_ready_early;
                if (bready && bvalid) begin
                    cpl_valid = !posted;  // only I/O writes complete
                    bready_next = 1'b0;
                    cq_tready_next = cc_ready_early;
                    state_next = ST_IDLE;
                end
            end
            ST_WAIT_END: begin
                // drop the rest of an oversized request
                cq_tready_next = 1'b1;
                if (cq_accept && cq_tlast) begin
                    cq_tready_next = posted ? cc_ready_early : 1'b0;
                    state_next = posted ? ST_IDLE : ST_CPL;
                end
            end
            ST_CPL: begin
                cpl_valid = 1'b1;
                if (cc_ready_reg) begin
                    cq_tready_next = cc_ready_early;
                    state_next = ST_IDLE;
                end
            end
            default: state_next = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            cq_tready <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
            arvalid <= 1'b0;
            rready <= 1'b0;
            stat_err_cor <= 1'b0;
            stat_err_uncor <= 1'b0;
            cc_ready_reg <= 1'b0;
        end else begin
            state <= state_next;
            cq_tready <= cq_tready_next;
            awvalid <= awvalid_next;
            wvalid <= wvalid_next;
            bready <= bready_next;
            arvalid <= arvalid_next;
            rready <= rready_next;
            stat_err_cor <= cor_next;
            stat_err_uncor <= uncor_next;
            cc_ready_reg <= cc_ready_early;
        end
    end

    // request fields, loaded with the header beat
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && cq_accept) begin
            axil_addr <= hdr_addr;
            wdata <= req_data;
            requester_id <= hdr_requester_id;
            tag <= hdr_tag;
            tc <= hdr_tc;
            attr <= hdr_attr;
            first_be <= hdr_first_be;
            posted <= req_posted;
            cpl_data <= req_is_read && req_len_ok;
            if (!(req_is_read || req_is_write)) begin
                status <= CPL_UR;
            end else if (!req_len_ok) begin
                status <= CPL_CA;
            end else begin
                status <= CPL_SC;
            end
        end
    end

endmodule

// File: rtl/cq_req_decode.sv
// CQ descriptor field extraction and request classification
`include "pcie_axil_consts.svh"

module cq_req_decode
    import pcie_axil_pkg::*;
(
    input  pcie_data_t cq_tdata,
    input  axil_strb_t cq_tuser,  // first byte enable
    input  logic       cq_tlast,
    output axil_addr_t hdr_addr,
    output req_type_e  hdr_type,
    output req_id_t    hdr_requester_id,
    output tlp_tag_t   hdr_tag,
    output tlp_tc_t    hdr_tc,
    output tlp_attr_t  hdr_attr,
    output axil_strb_t hdr_first_be,
    output axil_data_t req_data,
    output logic       req_is_read,
    output logic       req_is_write,
    output logic       req_posted,
    output logic       req_len_ok
);
    dw_count_t hdr_length;

    // dword address, upper bits beyond the AXI-Lite space are dropped
    assign hdr_addr = {cq_tdata[$bits(axil_addr_t)-1:2], 2'b00};
    assign hdr_length = cq_tdata[`CQ_LEN_LSB +: $bits(dw_count_t)];
    assign hdr_type = req_type_e'(cq_tdata[`CQ_TYPE_LSB +: 4]);
    assign hdr_requester_id = cq_tdata[`CQ_REQ_ID_LSB +: $bits(req_id_t)];
    assign hdr_tag = cq_tdata[`CQ_TAG_LSB +: $bits(tlp_tag_t)];
    assign hdr_tc = cq_tdata[`CQ_TC_LSB +: $bits(tlp_tc_t)];
    assign hdr_attr = cq_tdata[`CQ_ATTR_LSB +: $bits(tlp_attr_t)];
    assign hdr_first_be = cq_tuser;
    assign req_data = cq_tdata[`CQ_DATA_LSB +: $bits(axil_data_t)];

    assign req_is_read = (hdr_type == REQ_MEM_READ) || (hdr_type == REQ_IO_READ);
    assign req_is_write = (hdr_type == REQ_MEM_WRITE) || (hdr_type == REQ_IO_WRITE);

    // messages sit at type codes 4'b11xx
    assign req_posted = (hdr_type == REQ_MEM_WRITE) || (hdr_type[3:2] == 2'b11);

    // single dword, whole TLP in this beat
    assign req_len_ok = cq_tlast && (hdr_length == dw_count_t'(1));

endmodule

// File: rtl/pcie_axil_pkg.sv
// vector typedefs plus request type, completion status and FSM state enums
`include "pcie_axil_consts.svh"

package pcie_axil_pkg;

    typedef logic [`PCIE_DATA_W-1:0] pcie_data_t;
    typedef logic [`PCIE_KEEP_W-1:0] pcie_keep_t;
    typedef logic [`AXIL_ADDR_W-1:0] axil_addr_t;
    typedef logic [`AXIL_DATA_W-1:0] axil_data_t;
    typedef logic [`AXIL_STRB_W-1:0] axil_strb_t;
    typedef logic [10:0]             dw_count_t;
    typedef logic [15:0]             req_id_t;
    typedef logic [7:0]              tlp_tag_t;
    typedef logic [2:0]              tlp_tc_t;
    typedef logic [2:0]              tlp_attr_t;
    typedef logic [`CPL_HDR_W-1:0]   cpl_hdr_t;

    typedef enum logic [3:0] {
        REQ_MEM_READ   = `REQ_TYPE_MEM_READ,
        REQ_MEM_WRITE  = `REQ_TYPE_MEM_WRITE,
        REQ_IO_READ    = `REQ_TYPE_IO_READ,
        REQ_IO_WRITE   = `REQ_TYPE_IO_WRITE,
        REQ_CFG_READ_0 = `REQ_TYPE_CFG_READ_0,
        REQ_MSG        = `REQ_TYPE_MSG,
        REQ_MSG_VENDOR = `REQ_TYPE_MSG_VENDOR,
        REQ_MSG_ATS    = `REQ_TYPE_MSG_ATS
    } req_type_e;

    typedef enum logic [2:0] {
        CPL_SC = `CPL_STATUS_SC, // successful completion
        CPL_UR = `CPL_STATUS_UR, // unsupported request
        CPL_CA = `CPL_STATUS_CA  // completer abort
    } cpl_status_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ,
        ST_WRITE,
        ST_WAIT_END,
        ST_CPL
    } fsm_state_e;

endpackage

// File: rtl/pcie_axil_consts.svh
// width, request type, completion status and CQ field position macros
`ifndef PCIE_AXIL_CONSTS_SVH
`define PCIE_AXIL_CONSTS_SVH

`define PCIE_DATA_W 256
`define PCIE_KEEP_W 8  // one bit per dword
`define AXIL_ADDR_W 32
`define AXIL_DATA_W 32
`define AXIL_STRB_W 4
`define CPL_HDR_W   96 // three header dwords

// request type codes
`define REQ_TYPE_MEM_READ   4'd0
`define REQ_TYPE_MEM_WRITE  4'd1
`define REQ_TYPE_IO_READ    4'd2
`define REQ_TYPE_IO_WRITE   4'd3
`define REQ_TYPE_CFG_READ_0 4'd8
`define REQ_TYPE_MSG        4'd12
`define REQ_TYPE_MSG_VENDOR 4'd13
`define REQ_TYPE_MSG_ATS    4'd14

// completion status codes
`define CPL_STATUS_SC 3'd0
`define CPL_STATUS_UR 3'd1
`define CPL_STATUS_CA 3'd4

// CQ descriptor field lsbs
`define CQ_LEN_LSB    64
`define CQ_TYPE_LSB   75
`define CQ_REQ_ID_LSB 80
`define CQ_TAG_LSB    96
`define CQ_TC_LSB     121
`define CQ_ATTR_LSB   124
`define CQ_DATA_LSB   128 // first payload dword

`endif
